// ==== Makefile ====
SIM := obj_dir/Vrv_core_tb

.PHONY: all run clean

all: run

$(SIM): flist.f $(wildcard hw/*.sv) tests/rv_core_tb.sv
	verilator --binary --timing --top-module rv_core_tb -f flist.f

# The trace is read at run time from the project root.
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// ==== flist.f ====
hw/rv_isa_pkg.sv
hw/core_cfg_pkg.sv
hw/branch_predictor.sv
hw/fetch_stage.sv
hw/pipeline_control.sv
hw/reg_file.sv
hw/execute_stage.sv
hw/rv_core_top.sv
tests/rv_core_tb.sv

// ==== hw/branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [rv_isa_pkg::XLEN-1:0] decode_pc,
    input  logic                        pred_en,
    input  logic                        result,
    input  logic [rv_isa_pkg::XLEN-1:0] exec_pc,
    output logic                        bht_taken
);
    import core_cfg_pkg::*;

    logic [1:0]        counters [2**BHT_AW];
    logic [BHT_AW-1:0] rd_idx;
    logic [BHT_AW-1:0] wr_idx;

    // Pc bits 1:0 are always zero, so the index starts at bit 2.
    assign rd_idx    = decode_pc[2 +: BHT_AW];
    assign wr_idx    = exec_pc[2 +: BHT_AW];
    assign bht_taken = counters[rd_idx][1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**BHT_AW; i++) begin
                counters[i] <= BHT_INIT;
            end
        end else if (pred_en) begin
            if (result && counters[wr_idx] != 2'b11) begin
                counters[wr_idx] <= counters[wr_idx] + 2'd1;
            end else if (!result && counters[wr_idx] != 2'b00) begin
                counters[wr_idx] <= counters[wr_idx] - 2'd1;
            end
        end
    end

endmodule

// ==== hw/core_cfg_pkg.sv ====
package core_cfg_pkg;

    typedef enum logic [1:0] {
        PC_SEQ           = 2'd0,
        PC_PREDICT       = 2'd1,
        PC_EXEC_TARGET   = 2'd2,
        PC_EXEC_FALLTHRU = 2'd3
    } pc_src_e;

    typedef enum logic [1:0] {
        WB_LINK = 2'd0,
        WB_ALU  = 2'd2
    } wb_src_e;

    localparam int IMEM_AW = 8;
    localparam int BHT_AW  = 6;

    localparam logic [1:0] BHT_INIT = 2'b01;    // Weakly not-taken.

    localparam logic [rv_isa_pkg::XLEN-1:0] RESET_PC = '0;

endpackage

// ==== hw/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [rv_isa_pkg::XLEN-1:0] decode_inst,
    input  logic [rv_isa_pkg::XLEN-1:0] decode_pc,
    input  logic [rv_isa_pkg::XLEN-1:0] rs1_data,
    input  logic [rv_isa_pkg::XLEN-1:0] rs2_data,
    input  logic                        decode_rs1_sel,
    input  logic                        decode_rs2_sel,
    input  logic                        exec_rs1_sel,
    input  logic                        exec_rs2_sel,
    input  logic                        alu1_sel,
    input  logic                        alu2_sel,
    input  logic                        brun,
    input  core_cfg_pkg::wb_src_e       wb_sel,
    output logic [rv_isa_pkg::XLEN-1:0] execute_inst,
    output logic [rv_isa_pkg::XLEN-1:0] exec_pc,
    output logic [rv_isa_pkg::XLEN-1:0] exec_target,
    output logic                        breq,
    output logic                        brlt,
    output logic [rv_isa_pkg::XLEN-1:0] writeback_inst,
    output logic [rv_isa_pkg::XLEN-1:0] wb_pc,
    output logic [rv_isa_pkg::XLEN-1:0] wb_data
);
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;

    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_out;
    logic [4:0]      shamt;
    opcode_e         op;
    logic            alt;

    always_ff @(posedge clk) begin
        if (rst) begin
            execute_inst   <= NOP_INST;
            writeback_inst <= NOP_INST;
        end else begin
            execute_inst   <= decode_inst;
            writeback_inst <= execute_inst;
        end
    end

    always_ff @(posedge clk) begin
        exec_pc <= decode_pc;
        rs1_q   <= decode_rs1_sel ? wb_data : rs1_data;
        rs2_q   <= decode_rs2_sel ? wb_data : rs2_data;
        wb_pc   <= exec_pc;
        wb_data <= (wb_sel == WB_LINK) ? exec_pc + XLEN'(4) : alu_out;
    end

    assign op  = opcode_of(execute_inst);
    assign alt = execute_inst[ALT_BIT];
    assign rs1 = exec_rs1_sel ? wb_data : rs1_q;    // Result of the instruction just ahead.
    assign rs2 = exec_rs2_sel ? wb_data : rs2_q;

    always_comb begin
        case (op)
            LUI, AUIPC: imm = imm_u(execute_inst);
            JAL:        imm = imm_j(execute_inst);
            BRANCH:     imm = imm_b(execute_inst);
            default:    imm = imm_i(execute_inst);
        endcase
    end

    assign alu_a = alu1_sel ? exec_pc : rs1;
    assign alu_b = alu2_sel ? imm : rs2;
    assign shamt = alu_b[4:0];

    always_comb begin
        alu_out = alu_a + alu_b;    // Address arithmetic for jumps, branches and AUIPC.
        if (op == LUI) begin
            alu_out = alu_b;
        end else if (op == ARI_ITYPE || op == ARI_RTYPE) begin
            case (funct3_of(execute_inst))
                3'b000: alu_out = (op == ARI_RTYPE && alt) ? alu_a - alu_b : alu_a + alu_b;
                3'b001: alu_out = alu_a << shamt;
                3'b010: alu_out = XLEN'($signed(alu_a) < $signed(alu_b));
                3'b011: alu_out = XLEN'(alu_a < alu_b);
                3'b100: alu_out = alu_a ^ alu_b;
                3'b101: begin
                    if (alt) begin
                        alu_out = $signed(alu_a) >>> shamt;
                    end else begin
                        alu_out = alu_a >> shamt;
                    end
                end
                3'b110: alu_out = alu_a | alu_b;
                default: alu_out = alu_a & alu_b;
            endcase
        end
    end

    // Bit 0 is zero for every aligned target, and JALR needs it cleared.
    assign exec_target = {alu_out[XLEN-1:1], 1'b0};

    assign breq = rs1 == rs2;
    assign brlt = brun ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));

endmodule

// ==== hw/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  core_cfg_pkg::pc_src_e             pc_sel,
    input  logic [rv_isa_pkg::XLEN-1:0]       exec_target,
    input  logic [rv_isa_pkg::XLEN-1:0]       exec_pc,
    input  logic                              pred_en,
    input  logic                              result,
    input  logic                              imem_we,
    input  logic [core_cfg_pkg::IMEM_AW-1:0]  imem_addr,
    input  logic [rv_isa_pkg::XLEN-1:0]       imem_wdata,
    output logic [rv_isa_pkg::XLEN-1:0]       decode_inst,
    output logic [rv_isa_pkg::XLEN-1:0]       decode_pc,
    output logic                              predict
);
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;

    logic [XLEN-1:0]    imem [2**IMEM_AW];
    logic [XLEN-1:0]    fetch_pc;
    logic [XLEN-1:0]    branch_target;
    logic [IMEM_AW-1:0] imem_raddr;
    logic               bht_taken;

    branch_predictor branch_predictor_inst (
        .clk       (clk),
        .rst       (rst),
        .decode_pc (decode_pc),
        .pred_en   (pred_en),
        .result    (result),
        .exec_pc   (exec_pc),
        .bht_taken (bht_taken)
    );

    assign branch_target = decode_pc + imm_b(decode_inst);
    assign predict       = opcode_of(decode_inst) == BRANCH && bht_taken;

    always_comb begin
        case (pc_sel)
            PC_PREDICT:       fetch_pc = branch_target;
            PC_EXEC_TARGET:   fetch_pc = exec_target;
            PC_EXEC_FALLTHRU: fetch_pc = exec_pc + XLEN'(4);
            default:          fetch_pc = decode_pc + XLEN'(4);
        endcase
    end

    // While in reset the memory keeps reading the reset pc, so decode holds
    // a real instruction in the first cycle after release.
    assign imem_raddr = rst ? RESET_PC[2 +: IMEM_AW] : fetch_pc[2 +: IMEM_AW];

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
        decode_inst <= imem[imem_raddr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            decode_pc <= RESET_PC;
        end else begin
            decode_pc <= fetch_pc;
        end
    end

endmodule

// ==== hw/pipeline_control.sv ====
`timescale 1ns/1ps

module pipeline_control (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [rv_isa_pkg::XLEN-1:0] decode_inst,
    input  logic [rv_isa_pkg::XLEN-1:0] execute_inst,
    input  logic [rv_isa_pkg::XLEN-1:0] writeback_inst,
    input  logic                        predict,
    input  logic                        breq,
    input  logic                        brlt,
    output core_cfg_pkg::pc_src_e       pc_sel,
    output logic                        pred_en,
    output logic                        result,
    output logic                        decode_rs1_sel,
    output logic                        decode_rs2_sel,
    output logic                        exec_rs1_sel,
    output logic                        exec_rs2_sel,
    output logic                        alu1_sel,
    output logic                        alu2_sel,
    output logic                        brun,
    output core_cfg_pkg::wb_src_e       wb_sel,
    output logic                        rf_we,
    output logic                        retire_valid
);
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;

    logic              execute_valid;
    logic              writeback_valid;
    logic              execute_predict;
    logic              branch_cond;
    logic              taken;
    logic              mispredict;
    logic              fwd_ok;
    opcode_e           exe_op;
    opcode_e           wb_op;
    branch_fn_e        exe_fn;
    logic [REG_AW-1:0] wb_rd;

    assign exe_op = opcode_of(execute_inst);
    assign wb_op  = opcode_of(writeback_inst);
    assign exe_fn = branch_fn_e'(funct3_of(execute_inst));
    assign wb_rd  = rd_of(writeback_inst);

    always_comb begin
        case (exe_fn)
            BEQ:       branch_cond = breq;
            BNE:       branch_cond = ~breq;
            BLT, BLTU: branch_cond = brlt;
            BGE, BGEU: branch_cond = ~brlt;
            default:   branch_cond = 1'b0;
        endcase
    end

    // Jumps are never predicted, so they always redirect from execute.
    assign taken = exe_op == JAL || exe_op == JALR || (exe_op == BRANCH && branch_cond);
    assign mispredict = execute_valid && (execute_predict != taken);

    always_comb begin
        if (mispredict) begin
            pc_sel = execute_predict ? PC_EXEC_FALLTHRU : PC_EXEC_TARGET;
        end else if (predict) begin
            pc_sel = PC_PREDICT;
        end else begin
            pc_sel = PC_SEQ;
        end
    end

    assign pred_en = execute_valid && exe_op == BRANCH;
    assign result  = pred_en && branch_cond;

    always_comb begin
        case (wb_op)
            JAL, JALR, LUI, AUIPC, ARI_ITYPE, ARI_RTYPE: rf_we = writeback_valid;
            default:                                     rf_we = 1'b0;
        endcase
    end

    assign fwd_ok         = rf_we && wb_rd != '0;
    assign decode_rs1_sel = fwd_ok && rs1_of(decode_inst) == wb_rd;
    assign decode_rs2_sel = fwd_ok && rs2_of(decode_inst) == wb_rd;
    assign exec_rs1_sel   = fwd_ok && execute_valid && rs1_of(execute_inst) == wb_rd;
    assign exec_rs2_sel   = fwd_ok && execute_valid && rs2_of(execute_inst) == wb_rd;

    assign alu1_sel = exe_op == AUIPC || exe_op == JAL || exe_op == BRANCH;
    assign alu2_sel = exe_op != ARI_RTYPE;
    assign brun     = exe_fn == BLTU || exe_fn == BGEU;
    assign wb_sel   = (exe_op == JAL || exe_op == JALR) ? WB_LINK : WB_ALU;

    assign retire_valid = writeback_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            execute_valid   <= 1'b0;
            writeback_valid <= 1'b0;
            execute_predict <= 1'b0;
        end else begin
            execute_valid   <= ~mispredict;    // Decode is on the wrong path.
            writeback_valid <= execute_valid;
            execute_predict <= predict;
        end
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                          clk,
    input  logic [rv_isa_pkg::REG_AW-1:0] rs1_addr,
    input  logic [rv_isa_pkg::REG_AW-1:0] rs2_addr,
    input  logic                          we,
    input  logic [rv_isa_pkg::REG_AW-1:0] rd_addr,
    input  logic [rv_isa_pkg::XLEN-1:0]   rd_data,
    output logic [rv_isa_pkg::XLEN-1:0]   rs1_data,
    output logic [rv_isa_pkg::XLEN-1:0]   rs2_data
);
    import rv_isa_pkg::*;

    logic [XLEN-1:0] regs [2**REG_AW];

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

endmodule

// ==== hw/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              imem_we,
    input  logic [core_cfg_pkg::IMEM_AW-1:0]  imem_addr,
    input  logic [rv_isa_pkg::XLEN-1:0]       imem_wdata,
    output logic                              retire_valid,
    output logic [rv_isa_pkg::XLEN-1:0]       retire_pc,
    output logic                              retire_we,
    output logic [rv_isa_pkg::REG_AW-1:0]     retire_rd,
    output logic [rv_isa_pkg::XLEN-1:0]       retire_data
);
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;

    logic [XLEN-1:0] decode_inst;
    logic [XLEN-1:0] decode_pc;
    logic [XLEN-1:0] execute_inst;
    logic [XLEN-1:0] exec_pc;
    logic [XLEN-1:0] exec_target;
    logic [XLEN-1:0] writeback_inst;
    logic [XLEN-1:0] wb_pc;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic            predict;
    logic            pred_en;
    logic            result;
    logic            breq;
    logic            brlt;
    logic            decode_rs1_sel;
    logic            decode_rs2_sel;
    logic            exec_rs1_sel;
    logic            exec_rs2_sel;
    logic            alu1_sel;
    logic            alu2_sel;
    logic            brun;
    logic            rf_we;
    pc_src_e         pc_sel;
    wb_src_e         wb_sel;

    fetch_stage fetch_stage_inst (
        .clk         (clk),
        .rst         (rst),
        .pc_sel      (pc_sel),
        .exec_target (exec_target),
        .exec_pc     (exec_pc),
        .pred_en     (pred_en),
        .result      (result),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .decode_inst (decode_inst),
        .decode_pc   (decode_pc),
        .predict     (predict)
    );

    pipeline_control pipeline_control_inst (
        .clk            (clk),
        .rst            (rst),
        .decode_inst    (decode_inst),
        .execute_inst   (execute_inst),
        .writeback_inst (writeback_inst),
        .predict        (predict),
        .breq           (breq),
        .brlt           (brlt),
        .pc_sel         (pc_sel),
        .pred_en        (pred_en),
        .result         (result),
        .decode_rs1_sel (decode_rs1_sel),
        .decode_rs2_sel (decode_rs2_sel),
        .exec_rs1_sel   (exec_rs1_sel),
        .exec_rs2_sel   (exec_rs2_sel),
        .alu1_sel       (alu1_sel),
        .alu2_sel       (alu2_sel),
        .brun           (brun),
        .wb_sel         (wb_sel),
        .rf_we          (rf_we),
        .retire_valid   (retire_valid)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .rs1_addr (rs1_of(decode_inst)),
        .rs2_addr (rs2_of(decode_inst)),
        .we       (rf_we),
        .rd_addr  (rd_of(writeback_inst)),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_stage execute_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .decode_inst    (decode_inst),
        .decode_pc      (decode_pc),
        .rs1_data       (rs1_data),
        .rs2_data       (rs2_data),
        .decode_rs1_sel (decode_rs1_sel),
        .decode_rs2_sel (decode_rs2_sel),
        .exec_rs1_sel   (exec_rs1_sel),
        .exec_rs2_sel   (exec_rs2_sel),
        .alu1_sel       (alu1_sel),
        .alu2_sel       (alu2_sel),
        .brun           (brun),
        .wb_sel         (wb_sel),
        .execute_inst   (execute_inst),
        .exec_pc        (exec_pc),
        .exec_target    (exec_target),
        .breq           (breq),
        .brlt           (brlt),
        .writeback_inst (writeback_inst),
        .wb_pc          (wb_pc),
        .wb_data        (wb_data)
    );

    assign retire_pc   = wb_pc;
    assign retire_we   = rf_we;
    assign retire_rd   = rd_of(writeback_inst);
    assign retire_data = wb_data;

endmodule

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // Instruction field positions.
    localparam int OPC_LSB = 2;
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int ALT_BIT = 30;    // Selects SUB and SRA.

    localparam logic [XLEN-1:0] NOP_INST = 32'h0000_0013;    // ADDI x0, x0, 0.

    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        ARI_ITYPE = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARI_RTYPE = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        CSR       = 5'b11100
    } opcode_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_fn_e;

    function automatic opcode_e opcode_of(input logic [XLEN-1:0] inst);
        return opcode_e'(inst[OPC_LSB +: 5]);
    endfunction

    function automatic logic [REG_AW-1:0] rd_of(input logic [XLEN-1:0] inst);
        return inst[RD_LSB +: REG_AW];
    endfunction

    function automatic logic [REG_AW-1:0] rs1_of(input logic [XLEN-1:0] inst);
        return inst[RS1_LSB +: REG_AW];
    endfunction

    function automatic logic [REG_AW-1:0] rs2_of(input logic [XLEN-1:0] inst);
        return inst[RS2_LSB +: REG_AW];
    endfunction

    function automatic logic [2:0] funct3_of(input logic [XLEN-1:0] inst);
        return inst[F3_LSB +: 3];
    endfunction

    function automatic logic [XLEN-1:0] imm_i(input logic [XLEN-1:0] inst);
        return {{20{inst[31]}}, inst[31:20]};
    endfunction

    function automatic logic [XLEN-1:0] imm_b(input logic [XLEN-1:0] inst);
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [XLEN-1:0] imm_u(input logic [XLEN-1:0] inst);
        return {inst[31:12], 12'b0};
    endfunction

    function automatic logic [XLEN-1:0] imm_j(input logic [XLEN-1:0] inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

endpackage

// ==== tests/core_trace.txt ====
// Per test: program word count and record count, then the program words,
// then one retire record per line: pc, write flag, rd, data.
0b 0b  // Arithmetic and immediates.
00500093 ffd00113 123451b7 00001217 002082b3 40208333
001123b3 00113433 0011c4b3 40115533 01c15593
00 1 01 00000005
04 1 02 fffffffd
08 1 03 12345000
0c 1 04 0000100c
10 1 05 00000002
14 1 06 00000008
18 1 07 00000001
1c 1 08 00000000
20 1 09 12345005
24 1 0a ffffffff
28 1 0b 0000000f
06 06  // Back-to-back dependencies.
00700093 00308113 002081b3 40118233 004202b3 00128293
00 1 01 00000007
04 1 02 0000000a
08 1 03 00000011
0c 1 04 0000000a
10 1 05 00000014
14 1 05 00000015
08 08  // Writes to x0, then load, store and CSR opcodes.
abcde037 00200193 0001a283 00302223 c0002373 003003b3 00900013 00000433
00 1 00 abcde000
04 1 03 00000002
08 0 00 00000000
0c 0 00 00000000
10 0 00 00000000
14 1 07 00000002
18 1 00 00000009
1c 1 08 00000000
10 0f  // Branch loop and compares.
00200093 00000113 00110133 fff08093 fe009ce3 fff00193 0001c463 00100213
0001e463 0011f463 00200213 0030d463 00300213 00008463 00400213 00218293
00 1 01 00000002
04 1 02 00000000
08 1 02 00000002
0c 1 01 00000001
10 0 00 00000000
08 1 02 00000003
0c 1 01 00000000
10 0 00 00000000
14 1 03 ffffffff
18 0 00 00000000
20 0 00 00000000
24 0 00 00000000
2c 0 00 00000000
34 0 00 00000000
3c 1 05 00000001
0a 06  // JAL and JALR.
01100093 00c0016f 00100193 00200193 00808267 00300193 002202b3 0080006f
00400193 00128313
00 1 01 00000011
04 1 02 00000008
10 1 04 00000014
18 1 05 0000001c
1c 1 00 00000020
24 1 06 0000001d
00 00  // End of tests.

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;

    localparam int TRACE_WORDS  = 1024;
    localparam int RESET_CYCLES = 4;

    logic               clk;
    logic               rst;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [XLEN-1:0]    imem_wdata;
    logic               retire_valid;
    logic [XLEN-1:0]    retire_pc;
    logic               retire_we;
    logic [REG_AW-1:0]  retire_rd;
    logic [XLEN-1:0]    retire_data;

    logic [31:0] trace_mem [TRACE_WORDS];
    int          trace_pos;    // Start of the current test's words in trace_mem.
    int          test_count;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;
    logic        timed_out;

    rv_core_top rv_core_top_inst (
        .clk          (clk),
        .rst          (rst),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_we    (retire_we),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        $display("ERROR at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
        test_errors++;
    endtask

    // The core sits in reset while the program is written, one word per cycle.
    task automatic load_program(input int n_words);
        int i;
        rst = 1'b1;
        for (i = 0; i < n_words; i++) begin
            imem_we    = 1'b1;
            imem_addr  = IMEM_AW'(i);
            imem_wdata = trace_mem[trace_pos + i];
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
        end
        rst = 1'b0;
    endtask

    task automatic run_program(input int n_records);
        int rec;
        int cycles;
        int limit;
        int base;
        logic exp_we;
        rec    = 0;
        cycles = 0;
        limit  = 20 * n_records + 100;
        while (rec < n_records && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
            if (retire_valid === 1'b1) begin
                base   = trace_pos + 4 * rec;
                exp_we = trace_mem[base + 1][0];
                if (retire_pc !== trace_mem[base]) begin
                    report_mismatch("retire_pc", trace_mem[base], retire_pc);
                end
                if (retire_we !== exp_we) begin
                    report_mismatch("retire_we", XLEN'(exp_we), XLEN'(retire_we));
                end
                // Rd and data only mean something when a register is written.
                if (exp_we && retire_rd !== trace_mem[base + 2][REG_AW-1:0]) begin
                    report_mismatch("retire_rd", trace_mem[base + 2], XLEN'(retire_rd));
                end
                if (exp_we && retire_data !== trace_mem[base + 3]) begin
                    report_mismatch("retire_data", trace_mem[base + 3], retire_data);
                end
                rec++;
            end
        end
        if (rec < n_records) begin
            $display("Test %0d: the core stopped retiring after %0d of %0d records",
                     test_count, rec, n_records);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int n_words;
        int n_records;
        rst          = 1'b1;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        trace_pos    = 0;
        test_count   = 0;
        test_errors  = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        $readmemh("tests/core_trace.txt", trace_mem);
        @(posedge clk);
        #1;
        // A header with a zero program length ends the trace.
        while (!timed_out && trace_pos + 2 <= TRACE_WORDS && trace_mem[trace_pos] != '0) begin
            n_words   = int'(trace_mem[trace_pos]);
            n_records = int'(trace_mem[trace_pos + 1]);
            trace_pos += 2;
            test_count++;
            test_errors = 0;
            load_program(n_words);
            trace_pos += n_words;
            run_program(n_records);
            trace_pos += 4 * n_records;
            if (test_errors == 0 && !timed_out) begin
                tests_passed++;
                $display("Test %0d passed, %0d records", test_count, n_records);
            end else begin
                tests_failed++;
                $display("Test %0d failed, %0d errors", test_count, test_errors);
            end
        end
        if (test_count == 0) begin
            $display("No tests were found in tests/core_trace.txt");
            tests_failed++;
        end
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
